// File: axi_mem_top.f
source/axi_mem_pkg.sv
source/byte_ram.sv
source/byte_counter.sv
source/mem_datapath.sv
source/axi_mem_ctrl_fsm.sv
source/axi_mem_top.sv
verif/axi_mem_tb.sv

// File: source/axi_mem_ctrl_fsm.sv
// ------------------------------
// Channel handshake and byte-step FSM
// ------------------------------

`timescale 1ns/1ps

module axi_mem_ctrl_fsm import axi_mem_pkg::*; (
    input  logic clk,
    input  logic rst_n,

    input  logic arvalid,
    output logic arready,
    input  id_t  arid,
    output logic rvalid,
    input  logic rready,
    output id_t  rid,

    input  logic awvalid,
    output logic awready,
    input  id_t  awid,
    input  logic wvalid,
    output logic wready,
    output logic bvalid,
    input  logic bready,
    output id_t  bid,

    input  logic byte_last,
    output logic ar_take,
    output logic aw_take,
    output logic w_take,
    output logic byte_rd,
    output logic byte_we,
    output logic cnt_clear,
    output logic cnt_step
);

    typedef enum logic [2:0] {
        IDLE,
        WAIT_W,
        WAIT_AW,
        READ,
        WRITE,
        RRESP,
        BRESP
    } state_t;

    state_t state;
    state_t state_nxt;

    // ------------------------------
    // Readies and take strobes
    // ------------------------------
    // Reads win when AR and AW/W show up together
    assign arready = (state == IDLE);
    assign awready = ((state == IDLE) && !arvalid) || (state == WAIT_AW);
    assign wready  = ((state == IDLE) && !arvalid) || (state == WAIT_W);

    assign ar_take = arvalid && arready;
    assign aw_take = awvalid && awready;
    assign w_take  = wvalid && wready;

    // One byte per clock while stepping
    assign byte_rd   = (state == READ);
    assign byte_we   = (state == WRITE);
    assign cnt_clear = ar_take || aw_take;
    assign cnt_step  = byte_rd || byte_we;

    assign rvalid = (state == RRESP);
    assign bvalid = (state == BRESP);

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (ar_take) begin
                    state_nxt = READ;
                end else if (aw_take && w_take) begin
                    state_nxt = WRITE;
                end else if (aw_take) begin
                    state_nxt = WAIT_W;
                end else if (w_take) begin
                    state_nxt = WAIT_AW;
                end
            end
            WAIT_W:  if (w_take) state_nxt = WRITE;
            WAIT_AW: if (aw_take) state_nxt = WRITE;
            READ:    if (byte_last) state_nxt = RRESP;
            WRITE:   if (byte_last) state_nxt = BRESP;
            RRESP:   if (rready) state_nxt = IDLE;
            BRESP:   if (bready) state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // IDs are captured with the address
    always_ff @(posedge clk) begin
        if (ar_take) begin
            rid <= arid;
        end
        if (aw_take) begin
            bid <= awid;
        end
    end

endmodule

// File: source/axi_mem_pkg.sv
// ------------------------------
// Shared widths, sizes, addresses and types
// for the byte-serial AXI memory slave
// ------------------------------

package axi_mem_pkg;

    // Bus geometry
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;
    localparam int ID_W   = 4;
    localparam int LANE_W = $clog2(STRB_W);

    // Storage
    localparam int MEM_BYTES  = 4096;
    localparam int MEM_ADDR_W = $clog2(MEM_BYTES);

    // Interrupt register, bit 0 of the address is ignored on decode
    localparam logic [ADDR_W-1:0] IRQ_ADDR = 32'hF000_0100;
    localparam int IRQ_LINES = 16;
    localparam int IRQ_BYTES = IRQ_LINES / 8;

    localparam logic [1:0] RESP_OKAY = 2'b00;

    // ------------------------------
    // Types
    // ------------------------------
    typedef logic [ADDR_W-1:0]     addr_t;
    typedef logic [DATA_W-1:0]     data_t;
    typedef logic [STRB_W-1:0]     strb_t;
    typedef logic [ID_W-1:0]       id_t;
    typedef logic [LANE_W-1:0]     lane_t;
    typedef logic [2:0]            size_t;
    typedef logic [IRQ_LINES-1:0]  irq_t;
    typedef logic [MEM_ADDR_W-1:0] mem_idx_t;

endpackage

// File: source/axi_mem_top.sv
// ------------------------------
// AXI4 single-beat memory slave, top level
// Controller, byte counter and datapath
// ------------------------------

`timescale 1ns/1ps

module axi_mem_top import axi_mem_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,

    // Read address
    input  logic       arvalid,
    output logic       arready,
    input  id_t        arid,
    input  addr_t      araddr,
    input  size_t      arsize,

    // Read data
    output logic       rvalid,
    input  logic       rready,
    output id_t        rid,
    output data_t      rdata,
    output logic [1:0] rresp,
    output logic       rlast,

    // Write address
    input  logic       awvalid,
    output logic       awready,
    input  id_t        awid,
    input  addr_t      awaddr,
    input  size_t      awsize,

    // Write data, every beat is the last one
    input  logic       wvalid,
    output logic       wready,
    input  data_t      wdata,
    input  strb_t      wstrb,
    input  logic       wlast,

    // Write response
    output logic       bvalid,
    input  logic       bready,
    output id_t        bid,
    output logic [1:0] bresp,

    output irq_t       irq_lines
);

    logic  ar_take;
    logic  aw_take;
    logic  w_take;
    logic  byte_rd;
    logic  byte_we;
    logic  cnt_clear;
    logic  cnt_step;
    logic  byte_last;
    lane_t lane;
    lane_t start_lane;
    size_t size;

    // Single beat, always OKAY
    assign rresp = RESP_OKAY;
    assign rlast = 1'b1;
    assign bresp = RESP_OKAY;

    axi_mem_ctrl_fsm ctrl_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .arvalid   (arvalid),
        .arready   (arready),
        .arid      (arid),
        .rvalid    (rvalid),
        .rready    (rready),
        .rid       (rid),
        .awvalid   (awvalid),
        .awready   (awready),
        .awid      (awid),
        .wvalid    (wvalid),
        .wready    (wready),
        .bvalid    (bvalid),
        .bready    (bready),
        .bid       (bid),
        .byte_last (byte_last),
        .ar_take   (ar_take),
        .aw_take   (aw_take),
        .w_take    (w_take),
        .byte_rd   (byte_rd),
        .byte_we   (byte_we),
        .cnt_clear (cnt_clear),
        .cnt_step  (cnt_step)
    );

    byte_counter cnt_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .cnt_clear  (cnt_clear),
        .cnt_step   (cnt_step),
        .start_lane (start_lane),
        .size       (size),
        .lane       (lane),
        .byte_last  (byte_last)
    );

    mem_datapath dp_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .ar_take    (ar_take),
        .aw_take    (aw_take),
        .w_take     (w_take),
        .byte_rd    (byte_rd),
        .byte_we    (byte_we),
        .araddr     (araddr),
        .awaddr     (awaddr),
        .arsize     (arsize),
        .awsize     (awsize),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .lane       (lane),
        .start_lane (start_lane),
        .size       (size),
        .rdata      (rdata),
        .irq_lines  (irq_lines)
    );

endmodule

// File: source/byte_counter.sv
// ------------------------------
// Byte lane counter for one access
// ------------------------------

`timescale 1ns/1ps

module byte_counter import axi_mem_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  cnt_clear,
    input  logic  cnt_step,
    input  lane_t start_lane,
    input  size_t size,
    output lane_t lane,
    output logic  byte_last
);

    lane_t      offset;
    logic [7:0] size_bytes;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            offset <= '0;
        end else if (cnt_clear) begin
            offset <= '0;
        end else if (cnt_step) begin
            offset <= offset + lane_t'(1);
        end
    end

    assign lane = start_lane + offset;

    // Sizes wider than the bus stop at the top lane
    assign size_bytes = 8'd1 << size;
    assign byte_last  = (8'(offset) == (size_bytes - 8'd1)) || (lane == lane_t'(STRB_W - 1));

endmodule

// File: source/byte_ram.sv
// ------------------------------
// Byte-wide storage array
// ------------------------------

`timescale 1ns/1ps

module byte_ram import axi_mem_pkg::*; (
    input  logic       clk,
    input  logic       we,
    input  mem_idx_t   waddr,
    input  mem_idx_t   raddr,
    input  logic [7:0] wdata,
    output logic [7:0] rdata
);

    logic [7:0] mem [MEM_BYTES];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Asynchronous read
    assign rdata = mem[raddr];

endmodule

// File: source/mem_datapath.sv
// ------------------------------
// Request holding, IRQ decode,
// interrupt register and read assembly
// ------------------------------

`timescale 1ns/1ps

module mem_datapath import axi_mem_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  ar_take,
    input  logic  aw_take,
    input  logic  w_take,
    input  logic  byte_rd,
    input  logic  byte_we,
    input  addr_t araddr,
    input  addr_t awaddr,
    input  size_t arsize,
    input  size_t awsize,
    input  data_t wdata,
    input  strb_t wstrb,
    input  lane_t lane,
    output lane_t start_lane,
    output size_t size,
    output data_t rdata,
    output irq_t  irq_lines
);

    addr_t    addr_q;
    size_t    size_q;
    data_t    wdata_q;
    strb_t    wstrb_q;
    irq_t     irq_q;
    logic     irq_hit;
    mem_idx_t mem_idx;
    logic     byte_en;
    logic [7:0] wr_byte;
    logic [7:0] ram_byte;
    logic [7:0] irq_byte;
    logic [7:0] rd_byte;

    // Held request, only one transaction in flight
    always_ff @(posedge clk) begin
        if (ar_take) begin
            addr_q <= araddr;
            size_q <= arsize;
        end else if (aw_take) begin
            addr_q <= awaddr;
            size_q <= awsize;
        end
        if (w_take) begin
            wdata_q <= wdata;
            wstrb_q <= wstrb;
        end
    end

    assign start_lane = addr_q[LANE_W-1:0];
    assign size       = size_q;
    assign irq_hit    = (addr_q[ADDR_W-1:1] == IRQ_ADDR[ADDR_W-1:1]);

    // Walk from the held address by the offset into the access
    assign mem_idx = addr_q[MEM_ADDR_W-1:0] + mem_idx_t'(lane_t'(lane - start_lane));
    assign wr_byte = wdata_q[8*lane +: 8];
    assign byte_en = byte_we && wstrb_q[lane];

    // ------------------------------
    // Interrupt register
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            irq_q <= '0;
        end else if (byte_en && irq_hit) begin
            for (int i = 0; i < IRQ_BYTES; i++) begin
                if (lane == lane_t'(i)) begin
                    irq_q[8*i +: 8] <= wr_byte;
                end
            end
        end
    end

    always_comb begin
        irq_byte = '0;
        for (int i = 0; i < IRQ_BYTES; i++) begin
            if (lane == lane_t'(i)) begin
                irq_byte = irq_q[8*i +: 8];
            end
        end
    end

    assign irq_lines = irq_q;

    // ------------------------------
    // Storage and read word
    // ------------------------------
    byte_ram ram_i (
        .clk   (clk),
        .we    (byte_en && !irq_hit),
        .waddr (mem_idx),
        .raddr (mem_idx),
        .wdata (wr_byte),
        .rdata (ram_byte)
    );

    assign rd_byte = irq_hit ? irq_byte : ram_byte;

    // Untouched lanes stay zero
    always_ff @(posedge clk) begin
        if (ar_take) begin
            rdata <= '0;
        end else if (byte_rd) begin
            rdata[8*lane +: 8] <= rd_byte;
        end
    end

endmodule

// File: verif/axi_mem_tb.sv
// ------------------------------
// Testbench for the AXI memory slave
// AXI driver tasks, byte model, checks
// and cycle-limit timeout
// ------------------------------

`timescale 1ns/1ps

module axi_mem_tb import axi_mem_pkg::*; ();

    localparam int N_WORD     = 60;
    localparam int N_SUB      = 40;
    localparam int N_IRQ      = 8;
    localparam int N_MIX      = 16;
    localparam int WAIT_LIMIT = 20;
    // Every write and read issued over the run
    localparam int N_XFERS     = 2 * N_WORD + 2 * N_SUB + 6 + 2 * N_IRQ + N_MIX;
    localparam int CYCLE_LIMIT = 40 * N_XFERS + 100;

    logic       clk;
    logic       rst_n;
    logic       arvalid;
    logic       arready;
    id_t        arid;
    addr_t      araddr;
    size_t      arsize;
    logic       rvalid;
    logic       rready;
    id_t        rid;
    data_t      rdata;
    logic [1:0] rresp;
    logic       rlast;
    logic       awvalid;
    logic       awready;
    id_t        awid;
    addr_t      awaddr;
    size_t      awsize;
    logic       wvalid;
    logic       wready;
    data_t      wdata;
    strb_t      wstrb;
    logic       wlast;
    logic       bvalid;
    logic       bready;
    id_t        bid;
    logic [1:0] bresp;
    irq_t       irq_lines;

    // Reference model
    logic [7:0] mem_model [MEM_BYTES];
    irq_t       irq_model;
    addr_t      word_addrs [N_WORD];

    integer seed;
    int     pass_cnt = 0;
    int     fail_cnt = 0;
    int     cycles   = 0;

    axi_mem_top dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .arvalid   (arvalid),
        .arready   (arready),
        .arid      (arid),
        .araddr    (araddr),
        .arsize    (arsize),
        .rvalid    (rvalid),
        .rready    (rready),
        .rid       (rid),
        .rdata     (rdata),
        .rresp     (rresp),
        .rlast     (rlast),
        .awvalid   (awvalid),
        .awready   (awready),
        .awid      (awid),
        .awaddr    (awaddr),
        .awsize    (awsize),
        .wvalid    (wvalid),
        .wready    (wready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .wlast     (wlast),
        .bvalid    (bvalid),
        .bready    (bready),
        .bid       (bid),
        .bresp     (bresp),
        .irq_lines (irq_lines)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Run stopped after %0d cycles without finishing the tests", cycles);
            $display("TB FAILED");
            $finish;
        end
    end

    // ------------------------------
    // Checks and model
    // ------------------------------
    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            fail_cnt++;
            $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
        end else begin
            pass_cnt++;
        end
    endtask

    // Bytes touched: 2^size, cut at the top lane
    function automatic int num_bytes(input size_t s, input int ln);
        int n;
        n = 1 << s;
        if (n > STRB_W - ln) begin
            n = STRB_W - ln;
        end
        return n;
    endfunction

    function automatic logic irq_match(input addr_t a);
        return a[ADDR_W-1:1] == IRQ_ADDR[ADDR_W-1:1];
    endfunction

    task automatic model_write(input addr_t a, input size_t s, input data_t d, input strb_t st);
        int ln0;
        int ln;
        int k;
        ln0 = a[1:0];
        for (k = 0; k < num_bytes(s, ln0); k++) begin
            ln = ln0 + k;
            if (st[ln] && irq_match(a)) begin
                if (ln < IRQ_BYTES) begin
                    irq_model[8*ln +: 8] = d[8*ln +: 8];
                end
            end else if (st[ln]) begin
                mem_model[(a % MEM_BYTES + k) % MEM_BYTES] = d[8*ln +: 8];
            end
        end
    endtask

    function automatic data_t model_read(input addr_t a, input size_t s);
        data_t d;
        int    ln0;
        int    ln;
        int    k;
        d   = '0;
        ln0 = a[1:0];
        for (k = 0; k < num_bytes(s, ln0); k++) begin
            ln = ln0 + k;
            if (irq_match(a)) begin
                if (ln < IRQ_BYTES) begin
                    d[8*ln +: 8] = irq_model[8*ln +: 8];
                end
            end else begin
                d[8*ln +: 8] = mem_model[(a % MEM_BYTES + k) % MEM_BYTES];
            end
        end
        return d;
    endfunction

    // ------------------------------
    // AXI driver tasks
    // ------------------------------
    task automatic read_xfer(input string name, input id_t id, input addr_t a, input size_t s);
        int    waits;
        int    edges;
        logic  hs;
        data_t seen_data;
        id_t   seen_id;
        @(negedge clk);
        arvalid = 1'b1;
        arid    = id;
        araddr  = a;
        arsize  = s;
        waits   = 0;
        hs      = 1'b0;
        while (!hs && waits < WAIT_LIMIT) begin
            #1;
            hs = arready;
            @(posedge clk);
            @(negedge clk);
            waits++;
        end
        arvalid = 1'b0;
        if (!hs) begin
            fail_cnt++;
            $display("%s: read address was never accepted", name);
            return;
        end
        // Edges from the AR handshake to rvalid
        edges = 0;
        while (!rvalid && edges < WAIT_LIMIT) begin
            @(posedge clk);
            edges++;
            @(negedge clk);
        end
        if (!rvalid) begin
            fail_cnt++;
            $display("%s: rvalid never rose after the read request", name);
            return;
        end
        check($sformatf("%s rd_latency", name), num_bytes(s, a[1:0]), edges);
        check($sformatf("%s rdata", name), model_read(a, s), rdata);
        check($sformatf("%s rid", name), id, rid);
        check($sformatf("%s rresp", name), 0, rresp);
        check($sformatf("%s rlast", name), 1, rlast);
        check($sformatf("%s readies", name), 0, {arready, awready, wready});
        seen_data = rdata;
        seen_id   = rid;
        repeat ($unsigned($random(seed)) % 4) begin
            @(posedge clk);
            @(negedge clk);
            check($sformatf("%s rvalid held", name), 1, rvalid);
            check($sformatf("%s rdata held", name), seen_data, rdata);
            check($sformatf("%s rid held", name), seen_id, rid);
            check($sformatf("%s readies held", name), 0, {arready, awready, wready});
        end
        rready = 1'b1;
        @(posedge clk);
        @(negedge clk);
        rready = 1'b0;
    endtask

    // Order 0 sends AW first, 1 sends W first, 2 sends both together
    task automatic write_xfer(input string name, input id_t id, input addr_t a, input size_t s,
                              input data_t d, input strb_t st, input int order);
        int   waits;
        int   edges;
        logic aw_pend;
        logic w_pend;
        logic aw_hs;
        logic w_hs;
        id_t  seen_id;
        model_write(a, s, d, st);
        @(negedge clk);
        awid    = id;
        awaddr  = a;
        awsize  = s;
        wdata   = d;
        wstrb   = st;
        aw_pend = 1'b1;
        w_pend  = 1'b1;
        waits   = 0;
        while ((aw_pend || w_pend) && waits < WAIT_LIMIT) begin
            awvalid = aw_pend && (order != 1 || !w_pend);
            wvalid  = w_pend && (order != 0 || !aw_pend);
            #1;
            aw_hs = awvalid && awready;
            w_hs  = wvalid && wready;
            @(posedge clk);
            aw_pend = aw_pend && !aw_hs;
            w_pend  = w_pend && !w_hs;
            @(negedge clk);
            waits++;
        end
        awvalid = 1'b0;
        wvalid  = 1'b0;
        if (aw_pend || w_pend) begin
            fail_cnt++;
            $display("%s: write address or data was never accepted", name);
            return;
        end
        edges = 0;
        while (!bvalid && edges < WAIT_LIMIT) begin
            @(posedge clk);
            edges++;
            @(negedge clk);
        end
        if (!bvalid) begin
            fail_cnt++;
            $display("%s: bvalid never rose after the write", name);
            return;
        end
        check($sformatf("%s wr_latency", name), num_bytes(s, a[1:0]), edges);
        check($sformatf("%s bid", name), id, bid);
        check($sformatf("%s bresp", name), 0, bresp);
        check($sformatf("%s readies", name), 0, {arready, awready, wready});
        seen_id = bid;
        repeat ($unsigned($random(seed)) % 4) begin
            @(posedge clk);
            @(negedge clk);
            check($sformatf("%s bvalid held", name), 1, bvalid);
            check($sformatf("%s bid held", name), seen_id, bid);
            check($sformatf("%s readies held", name), 0, {arready, awready, wready});
        end
        bready = 1'b1;
        @(posedge clk);
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic end_test(input string name, input int fails_before);
        $display("Test %s finished with %0d failures", name, fail_cnt - fails_before);
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        int    fails_at;
        int    i;
        addr_t a;
        data_t d;
        seed      = 89;
        irq_model = '0;
        rst_n     = 1'b0;
        arvalid   = 1'b0;
        arid      = '0;
        araddr    = '0;
        arsize    = '0;
        rready    = 1'b0;
        awvalid   = 1'b0;
        awid      = '0;
        awaddr    = '0;
        awsize    = '0;
        wvalid    = 1'b0;
        wdata     = '0;
        wstrb     = '0;
        wlast     = 1'b1;
        bready    = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        fails_at = fail_cnt;
        check("reset rvalid", 0, rvalid);
        check("reset bvalid", 0, bvalid);
        check("reset irq_lines", 0, irq_lines);
        end_test("reset", fails_at);

        fails_at = fail_cnt;
        for (i = 0; i < N_WORD; i++) begin
            word_addrs[i] = $random(seed) & 32'h0000_FFFC;
            write_xfer("full_word", id_t'($random(seed)), word_addrs[i], 3'd2,
                       $random(seed), 4'hF, $unsigned($random(seed)) % 3);
        end
        for (i = 0; i < N_WORD; i++) begin
            read_xfer("full_word", id_t'($random(seed)), word_addrs[i], 3'd2);
        end
        end_test("full_word", fails_at);

        // Byte and halfword accesses inside words already written
        fails_at = fail_cnt;
        for (i = 0; i < N_SUB; i++) begin
            a = word_addrs[$unsigned($random(seed)) % N_WORD] | ($unsigned($random(seed)) % 4);
            write_xfer("sub_word", id_t'($random(seed)), a, size_t'($unsigned($random(seed)) % 2),
                       $random(seed), strb_t'($random(seed)), $unsigned($random(seed)) % 3);
            a = {a[ADDR_W-1:2], 2'(a[1:0] + $unsigned($random(seed)) % 4)};
            read_xfer("sub_word", id_t'($random(seed)), a, size_t'($unsigned($random(seed)) % 3));
        end
        end_test("sub_word", fails_at);

        fails_at = fail_cnt;
        d = $random(seed);
        for (i = 0; i < 3; i++) begin
            write_xfer("channel_order", id_t'($random(seed)), word_addrs[i], 3'd2, d, 4'hF, i);
        end
        for (i = 0; i < 3; i++) begin
            read_xfer("channel_order", id_t'($random(seed)), word_addrs[i], 3'd2);
        end
        end_test("channel_order", fails_at);

        fails_at = fail_cnt;
        check("irq_reg idle irq_lines", irq_model, irq_lines);
        for (i = 0; i < N_IRQ; i++) begin
            a = IRQ_ADDR | ($unsigned($random(seed)) % 2);
            write_xfer("irq_reg", id_t'($random(seed)), a, size_t'($unsigned($random(seed)) % 3),
                       $random(seed), strb_t'($random(seed)), $unsigned($random(seed)) % 3);
            check("irq_reg irq_lines", irq_model, irq_lines);
            read_xfer("irq_reg", id_t'($random(seed)), IRQ_ADDR, 3'd1);
        end
        end_test("irq_reg", fails_at);

        // Sizes up to 8 bytes, clipped at the top lane
        fails_at = fail_cnt;
        for (i = 0; i < N_MIX; i++) begin
            a = word_addrs[$unsigned($random(seed)) % N_WORD] | ($unsigned($random(seed)) % 4);
            if ($random(seed) & 1) begin
                write_xfer("latency_mix", id_t'($random(seed)), a,
                           size_t'($unsigned($random(seed)) % 4), $random(seed),
                           strb_t'($random(seed)), $unsigned($random(seed)) % 3);
            end else begin
                read_xfer("latency_mix", id_t'($random(seed)), a,
                          size_t'($unsigned($random(seed)) % 4));
            end
        end
        end_test("latency_mix", fails_at);

        $display("Checks passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
